// ==== rtl/core_pkg.sv ====
package core_pkg;

localparam int XLEN      = 32;
localparam int REG_IDX_W = 4;
localparam int NUM_REGS  = 1 << REG_IDX_W;

typedef logic [XLEN-1:0]      word_t;
typedef logic [REG_IDX_W-1:0] reg_idx_t;
typedef logic [3:0]           opcode_t;
typedef logic [1:0]           shift_op_t;
typedef logic [4:0]           shamt_t;
typedef logic [11:0]          imm_t;

localparam opcode_t OP_NOP = 4'd0;
localparam opcode_t OP_ADD = 4'd1;
localparam opcode_t OP_SUB = 4'd2;
localparam opcode_t OP_AND = 4'd3;
localparam opcode_t OP_ORR = 4'd4;
localparam opcode_t OP_EOR = 4'd5;
localparam opcode_t OP_MOV = 4'd6;
localparam opcode_t OP_LDR = 4'd7;
localparam opcode_t OP_STR = 4'd8;

localparam shift_op_t SH_LSL = 2'd0;
localparam shift_op_t SH_LSR = 2'd1;
localparam shift_op_t SH_ASR = 2'd2;
localparam shift_op_t SH_ROR = 2'd3;

// Instruction word, MSB first. rm sits in imm[3:0].
typedef struct packed {
        opcode_t   opcode;
        reg_idx_t  rd;
        reg_idx_t  rn;
        logic      imm_flag;
        shift_op_t shift_op;
        shamt_t    shamt;
        imm_t      imm;
} instr_t;

typedef struct packed {
        logic      valid;
        opcode_t   opcode;
        reg_idx_t  rd;
        shift_op_t shift_op;
        shamt_t    shamt;
        word_t     rn_val;
        word_t     op2;         // Before the shifter.
        word_t     st_data;
} exec_req_t;

typedef struct packed {
        logic     valid;
        logic     wb;
        logic     load;
        logic     store;
        reg_idx_t rd;
        word_t    result;       // ALU result or address.
        word_t    st_data;
} mem_req_t;

typedef struct packed {
        logic     en;
        reg_idx_t idx;
        word_t    data;
} wb_t;

endpackage

// ==== rtl/core_fetch.sv ====
`timescale 1ns/1ps

module core_fetch #(
        parameter core_pkg::word_t RESET_PC = '0
) (
        input  logic            i_clk,
        input  logic            i_rst_n,
        input  core_pkg::word_t i_instruction,
        input  logic            i_data_stall,
        input  logic            i_issue_stall,
        output core_pkg::word_t o_pc,
        output core_pkg::word_t o_instr,
        output logic            o_instr_valid
);

logic advance;

assign advance = !i_data_stall && !i_issue_stall;

// Instruction at o_pc is captured with the PC step.
always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
                o_pc          <= RESET_PC;
                o_instr_valid <= 1'b0;
        end else if (advance) begin
                o_pc          <= o_pc + 32'd4;
                o_instr       <= i_instruction;
                o_instr_valid <= 1'b1;
        end
end

// RESET_PC comes from the top level.
pc_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_pc[1:0] == 2'b00)
        else $error("fetch: PC not word aligned");

endmodule

// ==== rtl/core_issue.sv ====
`timescale 1ns/1ps

module core_issue (
        input  logic                i_clk,
        input  logic                i_rst_n,
        input  core_pkg::word_t     i_instr,
        input  logic                i_instr_valid,
        input  logic                i_data_stall,
        output core_pkg::reg_idx_t  o_rd_idx_a,
        output core_pkg::reg_idx_t  o_rd_idx_b,
        output core_pkg::reg_idx_t  o_rd_idx_c,
        input  core_pkg::word_t     i_rd_data_a,
        input  core_pkg::word_t     i_rd_data_b,
        input  core_pkg::word_t     i_rd_data_c,
        input  core_pkg::exec_req_t i_exec_req,
        output core_pkg::exec_req_t o_exec_req,
        output logic                o_issue_stall
);

core_pkg::instr_t    ins;
core_pkg::exec_req_t exec_nxt;
logic                op_known;
logic                uses_rn;
logic                uses_rm;
logic                uses_rd;

assign ins = core_pkg::instr_t'(i_instr);

// Unknown opcodes are treated as no-ops.
assign op_known = i_instr_valid && ins.opcode != core_pkg::OP_NOP &&
                  ins.opcode <= core_pkg::OP_STR;
assign uses_rn  = op_known && ins.opcode != core_pkg::OP_MOV;
assign uses_rm  = op_known && !ins.imm_flag;
assign uses_rd  = op_known && ins.opcode == core_pkg::OP_STR;   // Store data.

assign o_rd_idx_a = ins.rn;
assign o_rd_idx_b = ins.imm[3:0];
assign o_rd_idx_c = ins.rd;

// Writer in memory stage is covered by the regfile bypass.
assign o_issue_stall = i_exec_req.valid &&
                       ((uses_rn && ins.rn == i_exec_req.rd) ||
                        (uses_rm && ins.imm[3:0] == i_exec_req.rd) ||
                        (uses_rd && ins.rd == i_exec_req.rd));

always_comb begin
        exec_nxt.valid    = op_known && !o_issue_stall;
        exec_nxt.opcode   = ins.opcode;
        exec_nxt.rd       = ins.rd;
        exec_nxt.shift_op = ins.shift_op;
        exec_nxt.shamt    = ins.shamt;
        exec_nxt.rn_val   = i_rd_data_a;
        exec_nxt.op2      = ins.imm_flag ? core_pkg::word_t'(ins.imm) : i_rd_data_b;
        exec_nxt.st_data  = i_rd_data_c;
end

always_ff @(posedge i_clk) begin
        if (!i_rst_n)
                o_exec_req.valid <= 1'b0;
        else if (!i_data_stall)
                o_exec_req <= exec_nxt;
end

// The writer leaves execute on the next free edge.
stall_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_issue_stall && !i_data_stall |=> !o_issue_stall)
        else $error("issue: interlock held past one cycle");

endmodule

// ==== rtl/core_regfile.sv ====
`timescale 1ns/1ps

module core_regfile (
        input  logic               i_clk,
        input  logic               i_rst_n,
        input  core_pkg::reg_idx_t i_rd_idx_a,
        input  core_pkg::reg_idx_t i_rd_idx_b,
        input  core_pkg::reg_idx_t i_rd_idx_c,
        output core_pkg::word_t    o_rd_data_a,
        output core_pkg::word_t    o_rd_data_b,
        output core_pkg::word_t    o_rd_data_c,
        input  core_pkg::wb_t      i_wb
);

core_pkg::word_t regs [core_pkg::NUM_REGS];

// Same-cycle write is returned to the reader.
function automatic core_pkg::word_t read_port(core_pkg::reg_idx_t idx, core_pkg::wb_t wb,
                                              core_pkg::word_t stored);
        return (wb.en && wb.idx == idx) ? wb.data : stored;
endfunction

always_comb begin
        o_rd_data_a = read_port(i_rd_idx_a, i_wb, regs[i_rd_idx_a]);
        o_rd_data_b = read_port(i_rd_idx_b, i_wb, regs[i_rd_idx_b]);
        o_rd_data_c = read_port(i_rd_idx_c, i_wb, regs[i_rd_idx_c]);
end

always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
                for (int i = 0; i < core_pkg::NUM_REGS; i++)
                        regs[i] <= '0;
        end else if (i_wb.en) begin
                regs[i_wb.idx] <= i_wb.data;
        end
end

endmodule

// ==== rtl/core_execute.sv ====
`timescale 1ns/1ps

module core_execute (
        input  logic                i_clk,
        input  logic                i_rst_n,
        input  logic                i_data_stall,
        input  core_pkg::exec_req_t i_exec_req,
        output core_pkg::exec_req_t o_exec_req,
        output core_pkg::mem_req_t  o_mem_req
);

core_pkg::word_t    shifted;
core_pkg::word_t    result;
logic [63:0]        rot;
core_pkg::mem_req_t mem_nxt;
logic               is_store;

assign is_store = i_exec_req.opcode == core_pkg::OP_STR;
assign rot      = {i_exec_req.op2, i_exec_req.op2} >> i_exec_req.shamt;

// Barrel shifter on operand two.
always_comb begin
        case (i_exec_req.shift_op)
        core_pkg::SH_LSL: shifted = i_exec_req.op2 << i_exec_req.shamt;
        core_pkg::SH_LSR: shifted = i_exec_req.op2 >> i_exec_req.shamt;
        core_pkg::SH_ASR: shifted = core_pkg::word_t'($signed(i_exec_req.op2) >>>
                                                      i_exec_req.shamt);
        default:          shifted = rot[31:0];
        endcase
end

// Loads and stores use the adder for the address.
always_comb begin
        case (i_exec_req.opcode)
        core_pkg::OP_SUB: result = i_exec_req.rn_val - shifted;
        core_pkg::OP_AND: result = i_exec_req.rn_val & shifted;
        core_pkg::OP_ORR: result = i_exec_req.rn_val | shifted;
        core_pkg::OP_EOR: result = i_exec_req.rn_val ^ shifted;
        core_pkg::OP_MOV: result = shifted;
        default:          result = i_exec_req.rn_val + shifted;
        endcase
end

always_comb begin
        mem_nxt.valid   = i_exec_req.valid;
        mem_nxt.wb      = !is_store;
        mem_nxt.load    = i_exec_req.opcode == core_pkg::OP_LDR;
        mem_nxt.store   = is_store;
        mem_nxt.rd      = i_exec_req.rd;
        mem_nxt.result  = result;
        mem_nxt.st_data = i_exec_req.st_data;
end

// Only entries that write rd count for the interlock.
always_comb begin
        o_exec_req       = i_exec_req;
        o_exec_req.valid = i_exec_req.valid && !is_store;
end

always_ff @(posedge i_clk) begin
        if (!i_rst_n)
                o_mem_req.valid <= 1'b0;
        else if (!i_data_stall)
                o_mem_req <= mem_nxt;
end

endmodule

// ==== rtl/core_mem_wb.sv ====
`timescale 1ns/1ps

module core_mem_wb (
        input  core_pkg::mem_req_t i_mem_req,
        input  logic               i_data_stall,
        input  core_pkg::word_t    i_rd_data,
        output logic               o_read_en,
        output logic               o_write_en,
        output core_pkg::word_t    o_address,
        output core_pkg::word_t    o_wr_data,
        output core_pkg::wb_t      o_wb
);

// Port holds while stalled since the request register is frozen.
assign o_read_en  = i_mem_req.valid && i_mem_req.load;
assign o_write_en = i_mem_req.valid && i_mem_req.store;
assign o_address  = i_mem_req.result;
assign o_wr_data  = i_mem_req.st_data;

always_comb begin
        o_wb.en   = i_mem_req.valid && i_mem_req.wb && !i_data_stall;
        o_wb.idx  = i_mem_req.rd;
        o_wb.data = i_mem_req.load ? i_rd_data : i_mem_req.result;
end

// Flags are decoded in execute.
always_comb begin
        assert (o_read_en !== 1'b1 || o_write_en !== 1'b1)
                else $error("mem: read and write requested together");
end

endmodule

// ==== rtl/core_top.sv ====
`timescale 1ns/1ps

module core_top #(
        parameter core_pkg::word_t RESET_PC = '0
) (
        input  logic            i_clk,
        input  logic            i_rst_n,
        input  core_pkg::word_t i_instruction,
        input  logic            i_data_stall,
        input  core_pkg::word_t i_rd_data,
        output core_pkg::word_t o_pc,
        output logic            o_read_en,
        output logic            o_write_en,
        output core_pkg::word_t o_address,
        output core_pkg::word_t o_wr_data
);

core_pkg::word_t     fetch_instr;
logic                fetch_instr_valid;
logic                issue_stall;
core_pkg::reg_idx_t  rd_idx_a;
core_pkg::reg_idx_t  rd_idx_b;
core_pkg::reg_idx_t  rd_idx_c;
core_pkg::word_t     rd_data_a;
core_pkg::word_t     rd_data_b;
core_pkg::word_t     rd_data_c;
core_pkg::exec_req_t issue_exec_req;
core_pkg::exec_req_t exec_hazard_req;   // Back to issue.
core_pkg::mem_req_t  mem_req;
core_pkg::wb_t       wb;

core_fetch #(.RESET_PC(RESET_PC)) u_core_fetch (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_instruction(i_instruction),
        .i_data_stall(i_data_stall), .i_issue_stall(issue_stall),
        .o_pc(o_pc), .o_instr(fetch_instr), .o_instr_valid(fetch_instr_valid));

core_issue u_core_issue (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_instr(fetch_instr),
        .i_instr_valid(fetch_instr_valid), .i_data_stall(i_data_stall),
        .o_rd_idx_a(rd_idx_a), .o_rd_idx_b(rd_idx_b), .o_rd_idx_c(rd_idx_c),
        .i_rd_data_a(rd_data_a), .i_rd_data_b(rd_data_b), .i_rd_data_c(rd_data_c),
        .i_exec_req(exec_hazard_req), .o_exec_req(issue_exec_req),
        .o_issue_stall(issue_stall));

core_regfile u_core_regfile (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_rd_idx_a(rd_idx_a), .i_rd_idx_b(rd_idx_b), .i_rd_idx_c(rd_idx_c),
        .o_rd_data_a(rd_data_a), .o_rd_data_b(rd_data_b), .o_rd_data_c(rd_data_c),
        .i_wb(wb));

core_execute u_core_execute (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_data_stall(i_data_stall),
        .i_exec_req(issue_exec_req), .o_exec_req(exec_hazard_req), .o_mem_req(mem_req));

core_mem_wb u_core_mem_wb (
        .i_mem_req(mem_req), .i_data_stall(i_data_stall), .i_rd_data(i_rd_data),
        .o_read_en(o_read_en), .o_write_en(o_write_en), .o_address(o_address),
        .o_wr_data(o_wr_data), .o_wb(wb));

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
        parameter realtime PERIOD = 10.0
) (
        output logic o_clk
);

initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
end

endmodule

// ==== test/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;

localparam core_pkg::word_t RESET_PC = 32'h0000_1000;

logic clk, rst_n, data_stall, rd_en, wr_en;
core_pkg::word_t instruction, rd_data, pc, address, wr_data;
core_pkg::word_t prog_q[$], exp_addr_q[$], exp_data_q[$], obs_addr_q[$], obs_data_q[$];
core_pkg::word_t mem [core_pkg::word_t];
logic [31:0] lfsr = 32'h207f;
logic table_ready = 1'b0;
logic in_reset = 1'b1;
int n_seen = 0;

tb_clock #(.PERIOD(10.0)) u_tb_clock (.o_clk(clk));

core_top #(.RESET_PC(RESET_PC)) i_core_top (
        .i_clk(clk), .i_rst_n(rst_n), .i_instruction(instruction),
        .i_data_stall(data_stall), .i_rd_data(rd_data), .o_pc(pc),
        .o_read_en(rd_en), .o_write_en(wr_en), .o_address(address), .o_wr_data(wr_data));

task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
endtask

task automatic check_word(input string name, input core_pkg::word_t got, core_pkg::word_t exp);
        if (got !== exp)
                fail_now($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
endtask

task automatic check_bit(input string name, input logic got, logic exp);
        if (got !== exp)
                fail_now($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
endtask

function automatic core_pkg::word_t enc(core_pkg::opcode_t op, core_pkg::reg_idx_t rd,
                core_pkg::reg_idx_t rn, logic immf, core_pkg::shift_op_t sh,
                core_pkg::shamt_t amt, core_pkg::imm_t imm);
        return {op, rd, rn, immf, sh, amt, imm};
endfunction

// Fibonacci LFSR with taps 32 22 2 1.
function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic row(input core_pkg::word_t ins, logic st, core_pkg::word_t a, core_pkg::word_t d);
        prog_q.push_back(ins);
        if (st) begin
                exp_addr_q.push_back(a);
                exp_data_q.push_back(d);
        end
endtask

// STR r1 (0xF0) to the address r8 shifted.
task automatic shift_row(input core_pkg::shift_op_t sh, core_pkg::shamt_t amt, core_pkg::word_t a);
        row(enc(core_pkg::OP_STR, 1, 0, 0, sh, amt, 12'd8), 1, a, 32'hF0);
endtask

function automatic core_pkg::word_t fetch_word(core_pkg::word_t a);
        core_pkg::word_t idx;
        idx = (a - RESET_PC) >> 2;
        return (a >= RESET_PC && idx < prog_q.size()) ? prog_q[idx] : 32'h0;
endfunction

function automatic core_pkg::word_t mem_read(core_pkg::word_t a);
        return mem.exists(a) ? mem[a] : a ^ 32'hA5A5_A5A5;
endfunction

initial begin
        rst_n = 1'b0;
        data_stall = 1'b0;
        instruction = '0;
        rd_data = '0;
        mem[32'h200] = 32'hCAFE_F00D;
        mem[32'h300] = 32'h5A5A_1234;
        row(enc(core_pkg::OP_MOV, 1, 0, 1, core_pkg::SH_LSL, 0, 12'h0F0), 0, 0, 0);
        row(enc(core_pkg::OP_MOV, 2, 0, 1, core_pkg::SH_LSL, 20, 12'h123), 0, 0, 0);
        row(enc(core_pkg::OP_STR, 1, 0, 1, core_pkg::SH_LSL, 0, 12'h040), 1, 32'h40, 32'hF0);
        row(enc(core_pkg::OP_STR, 2, 0, 1, core_pkg::SH_LSL, 0, 12'h044), 1, 32'h44, 32'h1230_0000);
        row(enc(core_pkg::OP_ADD, 3, 1, 0, core_pkg::SH_LSL, 0, 12'h002), 0, 0, 0);
        row(enc(core_pkg::OP_STR, 3, 0, 1, core_pkg::SH_LSL, 0, 12'h048), 1, 32'h48, 32'h1230_00F0);
        row(enc(core_pkg::OP_SUB, 4, 2, 1, core_pkg::SH_LSL, 0, 12'h001), 0, 0, 0);
        row(enc(core_pkg::OP_STR, 4, 0, 1, core_pkg::SH_LSL, 0, 12'h04C), 1, 32'h4C, 32'h122F_FFFF);
        row(enc(core_pkg::OP_AND, 5, 3, 0, core_pkg::SH_LSL, 0, 12'h001), 0, 0, 0);
        row(enc(core_pkg::OP_ORR, 6, 1, 1, core_pkg::SH_LSL, 0, 12'hF00), 0, 0, 0);
        row(enc(core_pkg::OP_EOR, 7, 6, 0, core_pkg::SH_LSL, 0, 12'h001), 0, 0, 0);
        row(enc(core_pkg::OP_ADD, 9, 1, 1, core_pkg::SH_LSL, 4, 12'h005), 0, 0, 0);
        row(enc(core_pkg::OP_STR, 5, 0, 1, core_pkg::SH_LSL, 0, 12'h050), 1, 32'h50, 32'hF0);
        row(enc(core_pkg::OP_STR, 6, 0, 1, core_pkg::SH_LSL, 0, 12'h054), 1, 32'h54, 32'hFF0);
        row(enc(core_pkg::OP_STR, 7, 0, 1, core_pkg::SH_LSL, 0, 12'h058), 1, 32'h58, 32'hF00);
        row(enc(core_pkg::OP_STR, 9, 0, 1, core_pkg::SH_LSL, 0, 12'h05C), 1, 32'h5C, 32'h140);
        row(enc(core_pkg::OP_SUB, 11, 9, 0, core_pkg::SH_LSL, 0, 12'h001), 0, 0, 0);
        row(enc(core_pkg::OP_STR, 11, 0, 1, core_pkg::SH_LSL, 0, 12'h060), 1, 32'h60, 32'h50);
        row(enc(core_pkg::OP_AND, 12, 6, 1, core_pkg::SH_LSL, 0, 12'h3C3), 0, 0, 0);
        row(enc(core_pkg::OP_STR, 12, 0, 1, core_pkg::SH_LSL, 0, 12'h064), 1, 32'h64, 32'h3C0);
        row(enc(core_pkg::OP_ORR, 13, 2, 0, core_pkg::SH_LSL, 0, 12'h009), 0, 0, 0);
        row(enc(core_pkg::OP_STR, 13, 0, 1, core_pkg::SH_LSL, 0, 12'h068), 1, 32'h68, 32'h1230_0140);
        row(enc(core_pkg::OP_EOR, 14, 3, 1, core_pkg::SH_LSL, 0, 12'hFFF), 0, 0, 0);
        row(enc(core_pkg::OP_STR, 14, 0, 1, core_pkg::SH_LSL, 0, 12'h06C), 1, 32'h6C, 32'h1230_0F0F);
        row(enc(core_pkg::OP_MOV, 15, 7, 0, core_pkg::SH_LSL, 0, 12'h004), 0, 0, 0);
        row(enc(core_pkg::OP_STR, 15, 0, 1, core_pkg::SH_LSL, 0, 12'h070), 1, 32'h70, 32'h122F_FFFF);
        row(enc(core_pkg::OP_MOV, 8, 0, 1, core_pkg::SH_ROR, 1, 12'h003), 0, 0, 0);
        shift_row(core_pkg::SH_LSL, 0, 32'h8000_0001);
        shift_row(core_pkg::SH_LSL, 1, 32'h0000_0002);
        shift_row(core_pkg::SH_LSL, 31, 32'h8000_0000);
        shift_row(core_pkg::SH_LSL, 8, 32'h0000_0100);
        shift_row(core_pkg::SH_LSR, 0, 32'h8000_0001);
        shift_row(core_pkg::SH_LSR, 1, 32'h4000_0000);
        shift_row(core_pkg::SH_LSR, 31, 32'h0000_0001);
        shift_row(core_pkg::SH_LSR, 8, 32'h0080_0000);
        shift_row(core_pkg::SH_ASR, 0, 32'h8000_0001);
        shift_row(core_pkg::SH_ASR, 1, 32'hC000_0000);
        shift_row(core_pkg::SH_ASR, 31, 32'hFFFF_FFFF);
        shift_row(core_pkg::SH_ASR, 8, 32'hFF80_0000);
        shift_row(core_pkg::SH_ROR, 0, 32'h8000_0001);
        shift_row(core_pkg::SH_ROR, 1, 32'hC000_0000);
        shift_row(core_pkg::SH_ROR, 31, 32'h0000_0003);
        shift_row(core_pkg::SH_ROR, 8, 32'h0180_0000);
        row(enc(core_pkg::OP_LDR, 10, 9, 1, core_pkg::SH_LSL, 0, 12'h0C0), 0, 0, 0);
        row(enc(core_pkg::OP_STR, 10, 9, 1, core_pkg::SH_LSL, 0, 12'h0C4), 1, 32'h204, 32'hCAFE_F00D);
        row(enc(core_pkg::OP_LDR, 3, 0, 1, core_pkg::SH_LSL, 0, 12'h300), 0, 0, 0);
        row(enc(core_pkg::OP_STR, 3, 0, 1, core_pkg::SH_LSL, 0, 12'h308), 1, 32'h308, 32'h5A5A_1234);
        table_ready = 1'b1;
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
        in_reset = 1'b0;
        foreach (exp_addr_q[i]) begin
                while (obs_addr_q.size() == 0)
                        @(negedge clk);
                check_word("o_address", obs_addr_q.pop_front(), exp_addr_q[i]);
                check_word("o_wr_data", obs_data_q.pop_front(), exp_data_q[i]);
        end
        repeat (20) @(negedge clk);
        $display("=== PASS ===");
        $finish;
end

// Responses go out 1 ns after the edge.
always @(posedge clk) begin
        #1;
        instruction = fetch_word(pc);
        rd_data = rd_en ? mem_read(address) : '0;
        lfsr = lfsr_step(lfsr_step(lfsr));
        data_stall = lfsr[0] & lfsr[1];
end

logic prev_stall = 1'b0;
logic prev_rd, prev_wr;
core_pkg::word_t prev_pc, prev_addr, prev_wdata;

always @(negedge clk) begin
        if (in_reset) begin
                if ($time > 10) begin
                        check_bit("o_read_en", rd_en, 1'b0);
                        check_bit("o_write_en", wr_en, 1'b0);
                        check_word("o_pc", pc, RESET_PC);
                end
        end else begin
                if (pc != prev_pc)
                        check_word("o_pc", pc, prev_pc + 32'd4);
                if (prev_stall && (prev_rd || prev_wr)) begin  // Port holds.
                        check_bit("o_read_en", rd_en, prev_rd);
                        check_bit("o_write_en", wr_en, prev_wr);
                        check_word("o_address", address, prev_addr);
                        check_word("o_wr_data", wr_data, prev_wdata);
                end
                if (wr_en && !data_stall) begin
                        mem[address] = wr_data;
                        obs_addr_q.push_back(address);
                        obs_data_q.push_back(wr_data);
                        n_seen++;
                        if (n_seen > exp_addr_q.size())
                                fail_now("an extra store was seen");
                end
        end
        prev_pc = pc;
        prev_stall = data_stall;
        prev_rd = rd_en;
        prev_wr = wr_en;
        prev_addr = address;
        prev_wdata = wr_data;
end

initial begin
        wait (table_ready);
        repeat (16 + 40 * prog_q.size()) @(posedge clk);
        fail_now("timeout: expected stores did not all appear");
end

endmodule

// ==== all.f ====
rtl/core_pkg.sv
rtl/core_fetch.sv
rtl/core_issue.sv
rtl/core_regfile.sv
rtl/core_execute.sv
rtl/core_mem_wb.sv
rtl/core_top.sv
test/tb_clock.sv
test/core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds and runs core_tb; exit status is the simulation result.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f all.f --top-module core_tb -o core_sim
./obj_dir/core_sim
